/* logic/irq_pkg.sv */
// Shared definitions for the machine-mode interrupt controller
// Vector and id types, CSR write target select, WFI FSM states
// and the fixed interrupt line constants

package irq_pkg;

  // ------------------------------
  // Types
  // ------------------------------

  // One bit per interrupt line, same layout as mip and mie
  typedef logic [31:0] irq_vec_t;

  // Index of one interrupt line
  typedef logic [4:0] irq_id_t;

  // Target of a CSR write strobe
  typedef enum logic {
    CSR_MIE     = 1'b0,
    CSR_MSTATUS = 1'b1
  } csr_sel_e;

  // WFI sleep FSM
  typedef enum logic [1:0] {
    WFI_RUN   = 2'd0,
    WFI_DRAIN = 2'd1,
    WFI_SLEEP = 2'd2
  } wfi_state_e;

  // ------------------------------
  // Constants
  // ------------------------------

  // Implemented lines are 31..16 (platform), 11 (external), 7 (timer), 3 (software)
  localparam irq_vec_t VALID_IRQ_MASK = 32'hFFFF_0888;

  // Global enable and its saved copy inside mstatus write data
  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;

endpackage

/* logic/irq_csr.sv */
// Machine-mode interrupt CSR state
// mip  flopped interrupt inputs, reserved lines masked
// mie  per-line enables, written by the CSR write strobe
// mstatus MIE and MPIE, updated by acknowledge, CSR write and mret

`timescale 1ns/1ns

module irq_csr (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  irq_pkg::irq_vec_t  irq_i,
  input  logic               csr_we_i,
  input  irq_pkg::csr_sel_e  csr_sel_i,
  input  irq_pkg::irq_vec_t  csr_wdata_i,
  input  logic               mret_i,
  input  logic               irq_ack_i,
  output irq_pkg::irq_vec_t  mip_o,
  output irq_pkg::irq_vec_t  mie_o,
  output logic               mstatus_mie_o,
  output logic               mstatus_mpie_o
);

  import irq_pkg::*;

  irq_vec_t mip_q;
  irq_vec_t mie_q;
  logic     mie_glb_q;
  logic     mpie_q;

  // Write strobes split by target
  logic     we_mie;
  logic     we_mstatus;

  assign we_mie     = csr_we_i && (csr_sel_i == CSR_MIE);
  assign we_mstatus = csr_we_i && (csr_sel_i == CSR_MSTATUS);

  // ------------------------------
  // Pending register
  // ------------------------------

  // Samples the level inputs every edge, reserved lines never show up
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mip_q <= '0;
    end else begin
      mip_q <= irq_i & VALID_IRQ_MASK;
    end
  end

  // ------------------------------
  // Enable register
  // ------------------------------

  // Only the mie write touches this one, acknowledge leaves it alone
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mie_q <= '0;
    end else if (we_mie) begin
      mie_q <= csr_wdata_i & VALID_IRQ_MASK;
    end
  end

  // ------------------------------
  // Global enable, MIE and MPIE
  // ------------------------------

  // Priority: acknowledge, then mstatus write, then mret
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mie_glb_q <= 1'b0;
      mpie_q    <= 1'b0;
    end else if (irq_ack_i) begin
      // Trap entry: save the enable and mask further interrupts
      mpie_q    <= mie_glb_q;
      mie_glb_q <= 1'b0;
    end else if (we_mstatus) begin
      mie_glb_q <= csr_wdata_i[MSTATUS_MIE_BIT];
      mpie_q    <= csr_wdata_i[MSTATUS_MPIE_BIT];
    end else if (mret_i) begin
      // Trap return: restore the enable, MPIE goes back to 1
      mie_glb_q <= mpie_q;
      mpie_q    <= 1'b1;
    end
  end

  // Outputs straight from the registers
  assign mip_o          = mip_q;
  assign mie_o          = mie_q;
  assign mstatus_mie_o  = mie_glb_q;
  assign mstatus_mpie_o = mpie_q;

endmodule

/* logic/irq_arbiter.sv */
// Fixed-priority interrupt arbiter
// Winner over mip AND mie in the order 31..16, 11, 3, 7
// Registered single-cycle acknowledge with the winning id
// Any-enabled-pending flag for WFI wakeup

`timescale 1ns/1ns

module irq_arbiter (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  irq_pkg::irq_vec_t  mip_i,
  input  irq_pkg::irq_vec_t  mie_i,
  input  logic               mstatus_mie_i,
  output logic               irq_pending_o,
  output logic               irq_ack_o,
  output irq_pkg::irq_id_t   irq_id_o
);

  import irq_pkg::*;

  irq_vec_t pend_en;
  logic     win_valid;
  irq_id_t  win_id;
  logic     ack_q;
  irq_id_t  id_q;

  // Lines that are both pending and locally enabled
  assign pend_en = mip_i & mie_i;

  // Wakeup does not care about the global enable
  assign irq_pending_o = |pend_en;

  // ------------------------------
  // Winner selection
  // ------------------------------

  // Lowest priority first, each later hit overrides the earlier one
  always_comb begin
    win_valid = 1'b0;
    win_id    = '0;
    if (pend_en[7]) begin
      win_valid = 1'b1;
      win_id    = 5'd7;
    end
    if (pend_en[3]) begin
      win_valid = 1'b1;
      win_id    = 5'd3;
    end
    if (pend_en[11]) begin
      win_valid = 1'b1;
      win_id    = 5'd11;
    end
    // Platform lines, higher index wins
    for (int i = 16; i < 32; i++) begin
      if (pend_en[i]) begin
        win_valid = 1'b1;
        win_id    = irq_id_t'(i);
      end
    end
  end

  // ------------------------------
  // Acknowledge register
  // ------------------------------

  // No new ack while one is out, MIE drops on the edge after the ack
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
      id_q  <= '0;
    end else if (win_valid && mstatus_mie_i && !ack_q) begin
      ack_q <= 1'b1;
      id_q  <= win_id;
    end else begin
      ack_q <= 1'b0;
    end
  end

  assign irq_ack_o = ack_q;
  assign irq_id_o  = id_q;

endmodule

/* logic/wfi_ctrl.sv */
// WFI sleep controller
// RUN -> DRAIN on a retired WFI, DRAIN -> SLEEP once the pipeline is idle
// Wake on any enabled pending line or a debug request
// core_sleep_o is a decode of the SLEEP state

`timescale 1ns/1ns

module wfi_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic wfi_i,
  input  logic pipeline_idle_i,
  input  logic irq_pending_i,
  input  logic debug_req_i,
  output logic core_sleep_o
);

  import irq_pkg::*;

  wfi_state_e state_q;
  wfi_state_e state_d;
  logic       wake;

  // Wake ignores the global enable, the core resumes without taking a trap
  assign wake = irq_pending_i || debug_req_i;

  // ------------------------------
  // Next state
  // ------------------------------

  always_comb begin
    state_d = state_q;
    case (state_q)
      WFI_RUN: begin
        // WFI with a wake already present completes at once
        if (wfi_i && !wake) begin
          state_d = WFI_DRAIN;
        end
      end
      WFI_DRAIN: begin
        // Wait for outstanding work, abort on wake
        if (wake) begin
          state_d = WFI_RUN;
        end else if (pipeline_idle_i) begin
          state_d = WFI_SLEEP;
        end
      end
      WFI_SLEEP: begin
        if (wake) begin
          state_d = WFI_RUN;
        end
      end
      default: begin
        state_d = WFI_RUN;
      end
    endcase
  end

  // ------------------------------
  // State register
  // ------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= WFI_RUN;
    end else begin
      state_q <= state_d;
    end
  end

  // Sleep exactly in SLEEP, stray wfi_i strobes in DRAIN or SLEEP do nothing
  assign core_sleep_o = (state_q == WFI_SLEEP);

endmodule

/* logic/irq_ctrl_top.sv */
// Interrupt controller top level
// irq_csr      mip, mie and mstatus MIE/MPIE
// irq_arbiter  priority selection and acknowledge
// wfi_ctrl     core sleep and wakeup

`timescale 1ns/1ns

module irq_ctrl_top (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  irq_pkg::irq_vec_t  irq_i,
  input  logic               csr_we_i,
  input  irq_pkg::csr_sel_e  csr_sel_i,
  input  irq_pkg::irq_vec_t  csr_wdata_i,
  input  logic               mret_i,
  input  logic               wfi_i,
  input  logic               pipeline_idle_i,
  input  logic               debug_req_i,
  output logic               irq_ack_o,
  output irq_pkg::irq_id_t   irq_id_o,
  output logic               core_sleep_o,
  output irq_pkg::irq_vec_t  mip_o,
  output irq_pkg::irq_vec_t  mie_o,
  output logic               mstatus_mie_o,
  output logic               mstatus_mpie_o
);

  // Any enabled pending line, arbiter to WFI controller
  logic irq_pending;

  // CSR state, the ack feeds back to save and clear MIE
  irq_csr u_irq_csr (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .irq_i          (irq_i),
    .csr_we_i       (csr_we_i),
    .csr_sel_i      (csr_sel_i),
    .csr_wdata_i    (csr_wdata_i),
    .mret_i         (mret_i),
    .irq_ack_i      (irq_ack_o),
    .mip_o          (mip_o),
    .mie_o          (mie_o),
    .mstatus_mie_o  (mstatus_mie_o),
    .mstatus_mpie_o (mstatus_mpie_o)
  );

  irq_arbiter u_irq_arbiter (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .mip_i         (mip_o),
    .mie_i         (mie_o),
    .mstatus_mie_i (mstatus_mie_o),
    .irq_pending_o (irq_pending),
    .irq_ack_o     (irq_ack_o),
    .irq_id_o      (irq_id_o)
  );

  wfi_ctrl u_wfi_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .wfi_i           (wfi_i),
    .pipeline_idle_i (pipeline_idle_i),
    .irq_pending_i   (irq_pending),
    .debug_req_i     (debug_req_i),
    .core_sleep_o    (core_sleep_o)
  );

endmodule

/* tests/irq_ctrl_assert.sv */
// Concurrent protocol checks on the interrupt controller outputs
// Ack pulse width, ack id validity and enable, reserved mip bits

`timescale 1ns/1ns

module irq_ctrl_assert (
  input logic              clk_i,
  input logic              rst_ni,
  input logic              ack_i,
  input irq_pkg::irq_id_t  id_i,
  input irq_pkg::irq_vec_t mie_i,
  input irq_pkg::irq_vec_t mip_i
);

  import irq_pkg::*;

  ack_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni) ack_i |=> !ack_i)
    else $error("irq_ack_o high for more than one cycle");

  // Only implemented lines may be acknowledged
  ack_id_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ack_i |-> VALID_IRQ_MASK[id_i])
    else $error("acknowledged id is not an implemented line");

  ack_id_enabled: assert property (@(posedge clk_i) disable iff (!rst_ni) ack_i |-> mie_i[id_i])
    else $error("acknowledged id is not enabled in mie");

  mip_reserved: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mip_i & ~VALID_IRQ_MASK) == '0)
    else $error("mip has reserved bits set");

endmodule

bind irq_ctrl_top irq_ctrl_assert u_irq_ctrl_assert (
  .clk_i  (clk_i),
  .rst_ni (rst_ni),
  .ack_i  (irq_ack_o),
  .id_i   (irq_id_o),
  .mie_i  (mie_o),
  .mip_i  (mip_o)
);

/* tests/irq_ctrl_tb.sv */
// Testbench for the interrupt controller top level
// Clock and reset, random and directed stimulus, reference winner function
// Comparison process on every falling edge, timeout and verdict

`timescale 1ns/1ns

module irq_ctrl_tb;

  import irq_pkg::*;

  localparam int TIMEOUT_CYCLES = 20000;

  logic       clk_i;
  logic       rst_ni;
  irq_vec_t   irq_i;
  logic       csr_we_i;
  csr_sel_e   csr_sel_i;
  irq_vec_t   csr_wdata_i;
  logic       mret_i;
  logic       wfi_i;
  logic       pipeline_idle_i;
  logic       debug_req_i;
  logic       irq_ack_o;
  irq_id_t    irq_id_o;
  logic       core_sleep_o;
  irq_vec_t   mip_o;
  irq_vec_t   mie_o;
  logic       mstatus_mie_o;
  logic       mstatus_mpie_o;

  // irq_i as seen at the last two rising edges
  irq_vec_t   irq_q1;
  irq_vec_t   irq_q2;
  // Expected mie from the writes issued so far
  irq_vec_t   mie_model;
  logic [5:0] win;
  int         n_checks;
  int         n_errors;
  int         cycles;

  irq_ctrl_top dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Expected {valid, id} in the order 31..16 then 11, 3, 7
  function automatic logic [5:0] ref_winner(irq_vec_t irq, irq_vec_t en);
    irq_vec_t p;
    p = irq & en & VALID_IRQ_MASK;
    for (int i = 31; i >= 16; i--) begin
      if (p[i]) return {1'b1, i[4:0]};
    end
    if (p[11]) return {1'b1, 5'd11};
    if (p[3]) return {1'b1, 5'd3};
    if (p[7]) return {1'b1, 5'd7};
    return 6'b0;
  endfunction

  task automatic report_mismatch(string what, logic [31:0] got, logic [31:0] exp);
    $display("FAILED at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
    n_errors++;
  endtask

  task automatic expect_eq(logic [31:0] got, logic [31:0] exp, string what);
    n_checks++;
    if (got !== exp) report_mismatch(what, got, exp);
  endtask

  // Registered outputs are settled at the rising edge plus the drive delay
  task automatic next_edge();
    @(posedge clk_i);
    #2;
  endtask

  task automatic csr_write(csr_sel_e sel, irq_vec_t data);
    csr_we_i    = 1'b1;
    csr_sel_i   = sel;
    csr_wdata_i = data;
    next_edge();
    csr_we_i    = 1'b0;
    // Expected mie follows the write with the reserved lines dropped
    if (sel == CSR_MIE) begin
      mie_model = data & VALID_IRQ_MASK;
    end
  endtask

  // WFI with a busy pipeline, then idle, ends in SLEEP
  task automatic enter_sleep();
    pipeline_idle_i = 1'b0;
    wfi_i = 1'b1;
    next_edge();
    wfi_i = 1'b0;
    repeat (3) begin
      next_edge();
      expect_eq(core_sleep_o, 1'b0, "sleep while pipeline busy");
    end
    pipeline_idle_i = 1'b1;
    next_edge();
    expect_eq(core_sleep_o, 1'b1, "sleep after pipeline idle");
  endtask

  // Interrupt taken two edges after irq_i, then mret and a second take
  task automatic run_ack_tests();
    irq_vec_t   hit;
    irq_vec_t   en_val;
    irq_vec_t   irq_val;
    logic [5:0] exp;
    for (int n = 0; n < 100; n++) begin
      hit = (32'h1 << ($urandom % 32)) & VALID_IRQ_MASK;
      if (hit == '0) hit = 32'h80;
      en_val  = $urandom | hit;
      irq_val = $urandom | hit;
      exp     = ref_winner(irq_val, en_val);
      // Nothing pending while the enables are written
      irq_i  = '0;
      csr_write(CSR_MIE, en_val);
      csr_write(CSR_MSTATUS, 32'h1 << MSTATUS_MIE_BIT);
      irq_i  = irq_val;
      next_edge();
      expect_eq(irq_ack_o, 1'b0, "ack one edge after irq_i");
      next_edge();
      expect_eq(irq_ack_o, 1'b1, "ack two edges after irq_i");
      expect_eq(irq_id_o, exp[4:0], "ack id");
      next_edge();
      expect_eq(irq_ack_o, 1'b0, "ack pulse width");
      expect_eq(mstatus_mie_o, 1'b0, "MIE after ack");
      expect_eq(mstatus_mpie_o, 1'b1, "MPIE after ack");
      mret_i = 1'b1;
      next_edge();
      mret_i = 1'b0;
      expect_eq(mstatus_mie_o, 1'b1, "MIE after mret");
      next_edge();
      expect_eq(irq_ack_o, 1'b1, "ack again after mret");
      expect_eq(irq_id_o, exp[4:0], "ack id after mret");
      irq_i = '0;
      repeat (2) next_edge();
    end
  endtask

  // MIE clear, then no enabled line pending
  task automatic run_no_ack_tests();
    csr_write(CSR_MSTATUS, '0);
    csr_write(CSR_MIE, VALID_IRQ_MASK);
    irq_i = $urandom | 32'h800;
    repeat (10) begin
      next_edge();
      expect_eq(irq_ack_o, 1'b0, "ack with MIE clear");
    end
    irq_i = 32'h0000_0088;
    csr_write(CSR_MIE, 32'hFFFF_0800);
    csr_write(CSR_MSTATUS, 32'h1 << MSTATUS_MIE_BIT);
    repeat (10) begin
      next_edge();
      expect_eq(irq_ack_o, 1'b0, "ack with no enabled line");
    end
    irq_i = '0;
    csr_write(CSR_MSTATUS, '0);
  endtask

  // Sleep, wake on enabled irq with MIE clear, then wake on debug
  task automatic run_wfi_tests();
    csr_write(CSR_MIE, VALID_IRQ_MASK);
    next_edge();
    enter_sleep();
    irq_i = 32'h800;
    next_edge();
    expect_eq(core_sleep_o, 1'b1, "sleep one edge after irq_i");
    next_edge();
    expect_eq(core_sleep_o, 1'b0, "wake two edges after irq_i");
    repeat (4) begin
      next_edge();
      expect_eq(irq_ack_o, 1'b0, "ack after wake with MIE clear");
    end
    irq_i = '0;
    repeat (2) next_edge();
    enter_sleep();
    debug_req_i = 1'b1;
    next_edge();
    expect_eq(core_sleep_o, 1'b0, "wake on debug request");
    debug_req_i = 1'b0;
  endtask

  always @(posedge clk_i) begin
    irq_q1 <= irq_i;
    irq_q2 <= irq_q1;
  end

  // Compares mip and mie every cycle and the id of every ack
  always @(negedge clk_i) begin
    if (rst_ni) begin
      n_checks++;
      if (mip_o !== (irq_q1 & VALID_IRQ_MASK)) begin
        report_mismatch("mip_o", mip_o, irq_q1 & VALID_IRQ_MASK);
      end
      if (mie_o !== mie_model) begin
        report_mismatch("mie_o", mie_o, mie_model);
      end
      if (irq_ack_o) begin
        win = ref_winner(irq_q2, mie_model);
        if (!win[5] || irq_id_o !== win[4:0]) report_mismatch("ack id", irq_id_o, win[4:0]);
      end
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("=== FAIL ===");
      $finish;
    end
  end

  initial begin
    rst_ni          = 1'b0;
    irq_i           = '0;
    csr_we_i        = 1'b0;
    csr_sel_i       = CSR_MIE;
    csr_wdata_i     = '0;
    mret_i          = 1'b0;
    wfi_i           = 1'b0;
    pipeline_idle_i = 1'b0;
    debug_req_i     = 1'b0;
    mie_model       = '0;
    n_checks        = 0;
    n_errors        = 0;
    cycles          = 0;
    void'($urandom(50));
    repeat (3) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    // mip follows random irq_i while MIE is still clear from reset
    repeat (200) begin
      irq_i = $urandom;
      next_edge();
    end
    irq_i = '0;
    run_no_ack_tests();
    run_ack_tests();
    run_wfi_tests();
    repeat (2) next_edge();
    $display("Done: %0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* sim.f */
logic/irq_pkg.sv
logic/irq_csr.sv
logic/irq_arbiter.sv
logic/wfi_ctrl.sv
logic/irq_ctrl_top.sv
tests/irq_ctrl_assert.sv
tests/irq_ctrl_tb.sv

/* Bender.yml */
package:
  name: irq_ctrl

sources:
  - logic/irq_pkg.sv
  - logic/irq_csr.sv
  - logic/irq_arbiter.sv
  - logic/wfi_ctrl.sv
  - logic/irq_ctrl_top.sv
  - target: test
    files:
      - tests/irq_ctrl_assert.sv
      - tests/irq_ctrl_tb.sv
